/* alu/lane_alu.sv */
// Single lane integer ALU
`timescale 1ns/1ps
`default_nettype none

`include "ix_settings.svh"

module lane_alu(
    input wire ix_pkg::alu_op_t op,
    input wire ix_pkg::scalar_t a,
    input wire ix_pkg::scalar_t b,
    output ix_pkg::scalar_t y);

    import ix_pkg::*;

    localparam int W = `IX_SCALAR_WIDTH;

    scalar_t difference;
    logic borrow;
    logic negative;
    logic overflow;
    logic zero;
    logic signed_gtr;
    logic [`IX_SHIFT_BITS-1:0] shift_amount;
    logic shift_fill;
    logic [2*W-1:0] rshift_wide;
    count_t leading_zeros;
    count_t trailing_zeros;

    zero_counter zero_counter0(
        .value(b),
        .leading(leading_zeros),
        .trailing(trailing_zeros));

    // One wide subtract feeds every compare
    assign {borrow, difference} = {1'b0, a} - {1'b0, b};
    assign negative = difference[W-1];
    assign overflow = b[W-1] == negative && a[W-1] != b[W-1];
    assign zero = difference == '0;
    assign signed_gtr = overflow == negative;

    assign shift_amount = b[`IX_SHIFT_BITS-1:0];

    // Fill from the top with sign bits for arithmetic shifts
    assign shift_fill = (op == OP_ASHR) ? a[W-1] : 1'b0;
    assign rshift_wide = {{W{shift_fill}}, a} >> shift_amount;

    always_comb
    begin
        case (op)
            OP_SHR,
            OP_ASHR:
                y = rshift_wide[W-1:0];
            OP_SHL:
                y = a << shift_amount;
            OP_MOVE:
                y = b;
            OP_OR:
                y = a | b;
            OP_AND:
                y = a & b;
            OP_XOR:
                y = a ^ b;
            OP_CLZ:
                y = scalar_t'(leading_zeros);
            OP_CTZ:
                y = scalar_t'(trailing_zeros);
            OP_ADD:
                y = a + b;
            OP_SUB:
                y = difference;
            OP_CMPEQ:
                y = scalar_t'(zero);
            OP_CMPNE:
                y = scalar_t'(!zero);
            OP_CMPGT_I:
                y = scalar_t'(signed_gtr && !zero);
            OP_CMPGE_I:
                y = scalar_t'(signed_gtr || zero);
            OP_CMPLT_I:
                y = scalar_t'(!signed_gtr && !zero);
            OP_CMPLE_I:
                y = scalar_t'(!signed_gtr || zero);
            OP_CMPGT_U:
                y = scalar_t'(!borrow && !zero);
            OP_CMPGE_U:
                y = scalar_t'(!borrow || zero);
            OP_CMPLT_U:
                y = scalar_t'(borrow && !zero);
            OP_CMPLE_U:
                y = scalar_t'(borrow || zero);
            OP_SEXT8:
                y = scalar_t'($signed(b[7:0]));
            OP_SEXT16:
                y = scalar_t'($signed(b[15:0]));
            // Shuffle result comes from the vector level
            default:
                y = '0;
        endcase
    end

endmodule

`default_nettype wire

/* alu/vector_alu.sv */
// Vector ALU with cross-lane shuffle
`timescale 1ns/1ps
`default_nettype none

`include "ix_settings.svh"

module vector_alu(
    input wire ix_pkg::alu_op_t op,
    input wire ix_pkg::vector_t operand1,
    input wire ix_pkg::vector_t operand2,
    output ix_pkg::vector_t lane_result);

    import ix_pkg::*;

    genvar lane;
    generate
        for (lane = 0; lane < `IX_NUM_LANES; lane++)
        begin : lane_gen
            scalar_t alu_y;
            lane_idx_t src_lane;

            lane_alu lane_alu0(
                .op(op),
                .a(operand1[lane]),
                .b(operand2[lane]),
                .y(alu_y));

            // Source lane index sits in the low bits of operand 2
            assign src_lane = operand2[lane][$bits(lane_idx_t)-1:0];

            // Shuffle reaches across lanes, so it is picked here
            assign lane_result[lane] = (op == OP_SHUFFLE) ? operand1[src_lane] : alu_y;
        end
    endgenerate

endmodule

`default_nettype wire

/* alu/zero_counter.sv */
// Leading and trailing zero count
`timescale 1ns/1ps
`default_nettype none

`include "ix_settings.svh"

module zero_counter(
    input wire ix_pkg::scalar_t value,
    output ix_pkg::count_t leading,
    output ix_pkg::count_t trailing);

    import ix_pkg::*;

    localparam int W = `IX_SCALAR_WIDTH;

    // Highest set bit wins, scanning upward
    always_comb
    begin
        leading = count_t'(W);
        for (int i = 0; i < W; i++)
        begin
            if (value[i])
                leading = count_t'(W - 1 - i);
        end
    end

    // Lowest set bit wins, scanning downward
    always_comb
    begin
        trailing = count_t'(W);
        for (int i = W - 1; i >= 0; i--)
        begin
            if (value[i])
                trailing = count_t'(i);
        end
    end

endmodule

`default_nettype wire

/* common/ix_pkg.sv */
// Integer execute types
`default_nettype none

`include "ix_settings.svh"

package ix_pkg;

    typedef logic [`IX_SCALAR_WIDTH-1:0] scalar_t;
    typedef logic [`IX_NUM_LANES-1:0][`IX_SCALAR_WIDTH-1:0] vector_t;
    typedef logic [`IX_NUM_LANES-1:0] lane_mask_t;
    typedef logic [$clog2(`IX_NUM_LANES)-1:0] lane_idx_t;
    typedef logic [$clog2(`IX_NUM_THREADS)-1:0] thread_idx_t;

    // Zero count spans 0 to the full word width
    typedef logic [$clog2(`IX_SCALAR_WIDTH + 1)-1:0] count_t;

    typedef enum logic [4:0]
    {
        OP_SHR,
        OP_ASHR,
        OP_SHL,
        OP_MOVE,
        OP_OR,
        OP_AND,
        OP_XOR,
        OP_CLZ,
        OP_CTZ,
        OP_ADD,
        OP_SUB,
        OP_CMPEQ,
        OP_CMPNE,
        OP_CMPGT_I,
        OP_CMPGE_I,
        OP_CMPLT_I,
        OP_CMPLE_I,
        OP_CMPGT_U,
        OP_CMPGE_U,
        OP_CMPLT_U,
        OP_CMPLE_U,
        OP_SEXT8,
        OP_SEXT16,
        OP_SHUFFLE
    } alu_op_t;

    typedef enum logic [2:0]
    {
        BRANCH_ZERO,
        BRANCH_NOT_ZERO,
        BRANCH_ALWAYS,
        BRANCH_CALL_OFFSET,
        BRANCH_CALL_REGISTER,
        BRANCH_REGISTER
    } branch_type_t;

    typedef struct packed
    {
        alu_op_t alu_op;
        logic is_branch;
        branch_type_t branch_type;
        scalar_t pc;
        scalar_t immediate;
    } ix_instr_t;

    // From operand fetch
    typedef struct packed
    {
        logic valid;
        ix_instr_t instr;
        thread_idx_t thread_idx;
        vector_t operand1;
        vector_t operand2;
        lane_mask_t mask;
    } ix_issue_t;

    // Rollback request from writeback
    typedef struct packed
    {
        logic en;
        thread_idx_t thread_idx;
    } ix_squash_t;

    typedef struct packed
    {
        logic uncond_branch;
        logic cond_taken;
        logic cond_not_taken;
    } ix_perf_t;

    // Toward writeback
    typedef struct packed
    {
        logic valid;
        ix_instr_t instr;
        thread_idx_t thread_idx;
        vector_t result;
        lane_mask_t mask;
        logic rollback_en;
        scalar_t rollback_pc;
    } ix_result_t;

endpackage

`default_nettype wire

/* common/ix_settings.svh */
// Integer execute stage sizes
`ifndef IX_SETTINGS_SVH
`define IX_SETTINGS_SVH

// Vector lanes per instruction
`define IX_NUM_LANES 4

// Width of one lane word
`define IX_SCALAR_WIDTH 32

// Hardware threads sharing the pipeline
`define IX_NUM_THREADS 4

// Shift amount comes from the low bits of operand 2
`define IX_SHIFT_BITS 5

`endif

/* design/branch_resolve.sv */
// Branch resolution
`timescale 1ns/1ps
`default_nettype none

module branch_resolve(
    input wire logic accepted,
    input wire ix_pkg::ix_instr_t instr,
    input wire ix_pkg::scalar_t condition_value,
    output logic taken,
    output ix_pkg::scalar_t target,
    output ix_pkg::ix_perf_t perf_next);

    import ix_pkg::*;

    logic is_conditional;
    logic uncond;

    always_comb
    begin
        taken = 1'b0;
        is_conditional = 1'b0;
        uncond = 1'b0;

        if (accepted && instr.is_branch)
        begin
            case (instr.branch_type)
                BRANCH_ZERO:
                begin
                    taken = condition_value == '0;
                    is_conditional = 1'b1;
                end

                BRANCH_NOT_ZERO:
                begin
                    taken = condition_value != '0;
                    is_conditional = 1'b1;
                end

                BRANCH_ALWAYS,
                BRANCH_CALL_OFFSET,
                BRANCH_CALL_REGISTER,
                BRANCH_REGISTER:
                begin
                    taken = 1'b1;
                    uncond = 1'b1;
                end

                default:
                    ;
            endcase
        end
    end

    // Events for the performance counters
    assign perf_next = '{
        uncond_branch: uncond,
        cond_taken: is_conditional && taken,
        cond_not_taken: is_conditional && !taken
    };

    // Register forms jump to lane 0, the rest are PC relative
    always_comb
    begin
        case (instr.branch_type)
            BRANCH_CALL_REGISTER,
            BRANCH_REGISTER:
                target = condition_value;
            default:
                target = instr.pc + instr.immediate;
        endcase
    end

endmodule

`default_nettype wire

/* design/int_execute_stage.sv */
// Integer execute stage
`timescale 1ns/1ps
`default_nettype none

module int_execute_stage(
    input wire logic clk,
    input wire logic reset,
    input wire ix_pkg::ix_issue_t issue,
    input wire ix_pkg::ix_squash_t squash,
    output ix_pkg::ix_result_t result,
    output ix_pkg::ix_perf_t perf);

    import ix_pkg::*;

    logic accepted;
    vector_t lane_result;
    logic branch_taken;
    scalar_t branch_target;
    ix_perf_t perf_next;

    // Control state
    logic valid_q;
    logic rollback_en_q;
    ix_perf_t perf_q;

    // Payload
    ix_instr_t instr_q;
    thread_idx_t thread_idx_q;
    vector_t result_q;
    lane_mask_t mask_q;
    scalar_t rollback_pc_q;

    // Drop anything from a thread that writeback is rolling back
    assign accepted = issue.valid
        && (!squash.en || squash.thread_idx != issue.thread_idx);

    vector_alu vector_alu0(
        .op(issue.instr.alu_op),
        .operand1(issue.operand1),
        .operand2(issue.operand2),
        .lane_result(lane_result));

    // Branch condition and register targets come from lane 0
    branch_resolve branch_resolve0(
        .accepted(accepted),
        .instr(issue.instr),
        .condition_value(issue.operand1[0]),
        .taken(branch_taken),
        .target(branch_target),
        .perf_next(perf_next));

    always_ff @(posedge clk)
    begin
        instr_q <= issue.instr;
        thread_idx_q <= issue.thread_idx;
        result_q <= lane_result;
        mask_q <= issue.mask;
        rollback_pc_q <= branch_target;
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            valid_q <= 1'b0;
            rollback_en_q <= 1'b0;
            perf_q <= '0;
        end
        else
        begin
            valid_q <= accepted;
            // Taken is already qualified by accepted
            rollback_en_q <= branch_taken;
            perf_q <= perf_next;
        end
    end

    assign result = '{
        valid: valid_q,
        instr: instr_q,
        thread_idx: thread_idx_q,
        result: result_q,
        mask: mask_q,
        rollback_en: rollback_en_q,
        rollback_pc: rollback_pc_q
    };

    assign perf = perf_q;

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps --top-module tb_int_execute -f tb.f || exit 1
out="$(./obj_dir/Vtb_int_execute 2>&1)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Done: no errors" && echo "PASS" || { echo "FAIL"; exit 1; }

/* tb.f */
+incdir+common
+incdir+tb
common/ix_pkg.sv
alu/zero_counter.sv
alu/lane_alu.sv
alu/vector_alu.sv
design/branch_resolve.sv
design/int_execute_stage.sv
tb/tb_int_execute.sv

/* tb/ix_model.svh */
// Execute stage reference model
`ifndef IX_MODEL_SVH
`define IX_MODEL_SVH

// Fibonacci LFSR with taps at bits 32, 22, 2 and 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
endfunction

function automatic count_t count_leading(input scalar_t v);
    count_t n;
    n = '0;
    for (int i = `IX_SCALAR_WIDTH - 1; i >= 0 && !v[i]; i--)
        n++;
    return n;
endfunction

function automatic count_t count_trailing(input scalar_t v);
    count_t n;
    n = '0;
    for (int i = 0; i < `IX_SCALAR_WIDTH && !v[i]; i++)
        n++;
    return n;
endfunction

function automatic scalar_t expected_lane(input alu_op_t op, input scalar_t a, input scalar_t b);
    logic [`IX_SHIFT_BITS-1:0] sh;
    sh = b[`IX_SHIFT_BITS-1:0];
    case (op)
        OP_SHR: return a >> sh;
        OP_ASHR: return $signed(a) >>> sh;
        OP_SHL: return a << sh;
        OP_MOVE: return b;
        OP_OR: return a | b;
        OP_AND: return a & b;
        OP_XOR: return a ^ b;
        OP_CLZ: return scalar_t'(count_leading(b));
        OP_CTZ: return scalar_t'(count_trailing(b));
        OP_ADD: return a + b;
        OP_SUB: return a - b;
        OP_CMPEQ: return scalar_t'(a == b);
        OP_CMPNE: return scalar_t'(a != b);
        OP_CMPGT_I: return scalar_t'($signed(a) > $signed(b));
        OP_CMPGE_I: return scalar_t'($signed(a) >= $signed(b));
        OP_CMPLT_I: return scalar_t'($signed(a) < $signed(b));
        OP_CMPLE_I: return scalar_t'($signed(a) <= $signed(b));
        OP_CMPGT_U: return scalar_t'(a > b);
        OP_CMPGE_U: return scalar_t'(a >= b);
        OP_CMPLT_U: return scalar_t'(a < b);
        OP_CMPLE_U: return scalar_t'(a <= b);
        OP_SEXT8: return {{24{b[7]}}, b[7:0]};
        OP_SEXT16: return {{16{b[15]}}, b[15:0]};
        default: return '0;
    endcase
endfunction

function automatic vector_t expected_vector(input alu_op_t op, input vector_t a, input vector_t b);
    vector_t y;
    for (int l = 0; l < `IX_NUM_LANES; l++)
    begin
        // Shuffle picks the operand 1 lane named by operand 2
        if (op == OP_SHUFFLE)
            y[l] = a[lane_idx_t'(b[l])];
        else
            y[l] = expected_lane(op, a[l], b[l]);
    end
    return y;
endfunction

function automatic row_t model_row(input row_t r);
    logic accepted;
    logic conditional;
    logic taken;
    branch_type_t bt;
    bt = r.instr.branch_type;
    accepted = r.valid && !(r.squash.en && r.squash.thread_idx == r.thread_idx);
    conditional = bt == BRANCH_ZERO || bt == BRANCH_NOT_ZERO;
    if (bt == BRANCH_ZERO)
        taken = r.operand1[0] == '0;
    else if (bt == BRANCH_NOT_ZERO)
        taken = r.operand1[0] != '0;
    else
        taken = 1'b1;
    taken = taken && accepted && r.instr.is_branch;
    r.exp_valid = accepted;
    r.exp_result = expected_vector(r.instr.alu_op, r.operand1, r.operand2);
    r.exp_rollback = taken;
    if (bt == BRANCH_CALL_REGISTER || bt == BRANCH_REGISTER)
        r.exp_target = r.operand1[0];
    else
        r.exp_target = r.instr.pc + r.instr.immediate;
    r.exp_perf.uncond_branch = accepted && r.instr.is_branch && !conditional;
    r.exp_perf.cond_taken = conditional && taken;
    r.exp_perf.cond_not_taken = accepted && r.instr.is_branch && conditional && !taken;
    return r;
endfunction

`endif

/* tb/tb_int_execute.sv */
// Integer execute stage testbench
`timescale 1ns/1ps
`default_nettype none

`include "ix_settings.svh"

module tb_int_execute;

    import ix_pkg::*;

    localparam logic [31:0] LFSR_SEED = 32'h75ac17c7;

    typedef struct packed
    {
        logic valid;
        logic random_operands;
        logic use_model;
        ix_instr_t instr;
        thread_idx_t thread_idx;
        lane_mask_t mask;
        vector_t operand1;
        vector_t operand2;
        ix_squash_t squash;
        logic exp_valid;
        vector_t exp_result;
        logic exp_rollback;
        scalar_t exp_target;
        ix_perf_t exp_perf;
    } row_t;

    logic clk = 1'b0;
    logic reset = 1'b1;
    ix_issue_t issue = '0;
    ix_squash_t squash = '0;
    ix_result_t result;
    ix_perf_t perf;

    row_t rows[$];
    row_t pending;
    logic [31:0] lfsr_state = LFSR_SEED;
    int row_num = -1;
    int cycle_count = 0;

    `include "ix_model.svh"

    int_execute_stage dut0(
        .clk(clk),
        .reset(reset),
        .issue(issue),
        .squash(squash),
        .result(result),
        .perf(perf));

    always #10 clk = ~clk;

    // Generous bound on the table run time
    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= 16 + 4 * rows.size())
        begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_count);
            report_failure();
        end
    end

    task automatic report_failure();
        $display("Done: errors found");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_vector(input string name, input vector_t actual, input vector_t expected);
        if (actual !== expected)
        begin
            $display("CHECK FAILED row %0d %s: actual %h expected %h",
                row_num, name, actual, expected);
            report_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected)
        begin
            $display("CHECK FAILED row %0d %s: actual %h expected %h",
                row_num, name, actual, expected);
            report_failure();
        end
    endtask

    task automatic check_scalar(input string name, input scalar_t actual, input scalar_t expected);
        if (actual !== expected)
        begin
            $display("CHECK FAILED row %0d %s: actual %h expected %h",
                row_num, name, actual, expected);
            report_failure();
        end
    endtask

    task automatic check_perf(input string name, input ix_perf_t actual, input ix_perf_t expected);
        if (actual !== expected)
        begin
            $display("CHECK FAILED row %0d %s: actual %h expected %h",
                row_num, name, actual, expected);
            report_failure();
        end
    endtask

    task automatic check_instr(input string name, input ix_instr_t actual,
        input ix_instr_t expected);
        if (actual !== expected)
        begin
            $display("CHECK FAILED row %0d %s: actual %h expected %h",
                row_num, name, actual, expected);
            report_failure();
        end
    endtask

    // One LFSR step per bit taken
    task automatic random_vector(output vector_t v);
        for (int i = 0; i < $bits(vector_t); i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            v[i / `IX_SCALAR_WIDTH][i % `IX_SCALAR_WIDTH] = lfsr_state[0];
        end
    endtask

    function automatic row_t lane_row(input alu_op_t op, input vector_t a, input vector_t b,
        input logic rnd);
        row_t r;
        r = '0;
        r.valid = 1'b1;
        r.random_operands = rnd;
        r.use_model = 1'b1;
        r.instr.alu_op = op;
        r.instr.pc = 32'h0000_0100;
        // Vary mask and thread so carried fields change row to row
        r.mask = lane_mask_t'(op);
        r.thread_idx = thread_idx_t'(op);
        r.operand1 = a;
        r.operand2 = b;
        return r;
    endfunction

    function automatic row_t branch_row(input branch_type_t bt, input scalar_t cond,
        input logic squash_en, input thread_idx_t squash_thread);
        row_t r;
        r = lane_row(OP_MOVE, {32'h3, 32'h2, 32'h1, cond}, {4{32'h0000_00aa}}, 1'b0);
        r.instr.is_branch = 1'b1;
        r.instr.branch_type = bt;
        r.instr.pc = 32'h0000_1000;
        r.instr.immediate = 32'h0000_0040;
        r.thread_idx = 2'd2;
        r.mask = 4'b0101;
        r.squash.en = squash_en;
        r.squash.thread_idx = squash_thread;
        return r;
    endfunction

    // Hand-worked expectations for a lane row
    function automatic row_t expect_lanes(input row_t r, input vector_t y);
        r.use_model = 1'b0;
        r.exp_valid = 1'b1;
        r.exp_result = y;
        return r;
    endfunction

    // Branch rows run a move, so the result is operand 2
    function automatic row_t expect_branch(input row_t r, input scalar_t target,
        input ix_perf_t p);
        r.use_model = 1'b0;
        r.exp_valid = 1'b1;
        r.exp_result = r.operand2;
        r.exp_rollback = 1'b1;
        r.exp_target = target;
        r.exp_perf = p;
        return r;
    endfunction

    task automatic fill_rows();
        vector_t cmp_a;
        vector_t cmp_b;
        vector_t shift_a;
        vector_t shift_b;
        vector_t zc;
        vector_t shuf_a;
        cmp_a = {32'h8000_0000, 32'h0, 32'h8000_0000, 32'h7fff_ffff};
        cmp_b = {32'h8000_0000, 32'h0, 32'h7fff_ffff, 32'h8000_0000};
        shift_a = {32'h8000_00f1, 32'hf000_0001, 32'h1234_5678, 32'h8765_4321};
        shift_b = {32'd31, 32'd0, 32'd63, 32'd33};
        zc = {32'h8000_0000, 32'h1, 32'hffff_ffff, 32'h0};
        shuf_a = {32'hdddd_dddd, 32'hcccc_cccc, 32'hbbbb_bbbb, 32'haaaa_aaaa};
        rows.push_back(lane_row(OP_SHL, shift_a, shift_b, 1'b0));
        rows.push_back(lane_row(OP_SHR, shift_a, shift_b, 1'b0));
        rows.push_back(lane_row(OP_ASHR, shift_a, shift_b, 1'b0));
        rows.push_back(lane_row(OP_CLZ, '0, zc, 1'b0));
        rows.push_back(lane_row(OP_CTZ, '0, zc, 1'b0));
        rows.push_back(lane_row(OP_SEXT8, '0, shift_a, 1'b0));
        rows.push_back(lane_row(OP_SEXT16, '0, shift_a, 1'b0));
        rows.push_back(lane_row(OP_ADD, cmp_a, cmp_b, 1'b0));
        rows.push_back(lane_row(OP_SUB, cmp_a, cmp_b, 1'b0));
        // Only lane 0 has 0x7fffffff against 0x80000000
        rows.push_back(expect_lanes(lane_row(OP_CMPGT_I, cmp_a, cmp_b, 1'b0), 128'h1));
        rows.push_back(expect_lanes(lane_row(OP_CMPLT_U, cmp_a, cmp_b, 1'b0), 128'h1));
        for (int op = OP_CMPEQ; op <= OP_CMPLE_U; op++)
            rows.push_back(lane_row(alu_op_t'(op), cmp_a, cmp_b, 1'b0));
        for (int op = OP_SHR; op <= OP_SHUFFLE; op++)
            rows.push_back(lane_row(alu_op_t'(op), '0, '0, 1'b1));
        rows.push_back(expect_lanes(lane_row(OP_SHUFFLE, shuf_a, {32'h0, 32'h1, 32'h2, 32'h3},
            1'b0), {32'haaaa_aaaa, 32'hbbbb_bbbb, 32'hcccc_cccc, 32'hdddd_dddd}));
        rows.push_back(lane_row(OP_SHUFFLE, shuf_a, {32'h4, 32'h8, 32'hc, 32'h0}, 1'b0));
        // Perf bits are uncond, cond taken, cond not taken
        rows.push_back(expect_branch(branch_row(BRANCH_ZERO, '0, 1'b0, 2'd0), 32'h1040,
            3'b010));
        rows.push_back(expect_branch(branch_row(BRANCH_REGISTER, 32'h2000, 1'b0, 2'd0),
            32'h2000, 3'b100));
        rows.push_back(branch_row(BRANCH_ZERO, 32'h5, 1'b0, 2'd0));
        rows.push_back(branch_row(BRANCH_NOT_ZERO, '0, 1'b0, 2'd0));
        rows.push_back(branch_row(BRANCH_NOT_ZERO, 32'h8000_0000, 1'b0, 2'd0));
        rows.push_back(branch_row(BRANCH_ALWAYS, 32'h9, 1'b0, 2'd0));
        rows.push_back(branch_row(BRANCH_CALL_OFFSET, 32'h9, 1'b0, 2'd0));
        rows.push_back(branch_row(BRANCH_CALL_REGISTER, 32'h3000, 1'b0, 2'd0));
        // Squash aimed at the branch thread, then at another one
        rows.push_back(branch_row(BRANCH_ZERO, '0, 1'b1, 2'd2));
        rows.push_back(branch_row(BRANCH_ALWAYS, '0, 1'b1, 2'd2));
        rows.push_back(branch_row(BRANCH_ZERO, '0, 1'b1, 2'd1));
    endtask

    task automatic apply_row(input row_t r);
        row_t row;
        row = r;
        if (row.random_operands)
        begin
            random_vector(row.operand1);
            random_vector(row.operand2);
        end
        if (row.use_model)
            row = model_row(row);
        issue.valid = row.valid;
        issue.instr = row.instr;
        issue.thread_idx = row.thread_idx;
        issue.operand1 = row.operand1;
        issue.operand2 = row.operand2;
        issue.mask = row.mask;
        squash = row.squash;
        pending = row;
    endtask

    task automatic check_outputs(input row_t r);
        check_bit("result.valid", result.valid, r.exp_valid);
        check_bit("result.rollback_en", result.rollback_en, r.exp_rollback);
        check_perf("perf", perf, r.exp_perf);
        if (r.exp_valid)
        begin
            check_vector("result.result", result.result, r.exp_result);
            check_instr("result.instr", result.instr, r.instr);
            check_scalar("result.mask", scalar_t'(result.mask), scalar_t'(r.mask));
            check_scalar("result.thread_idx", scalar_t'(result.thread_idx),
                scalar_t'(r.thread_idx));
        end
        if (r.exp_rollback)
            check_scalar("result.rollback_pc", result.rollback_pc, r.exp_target);
    endtask

    initial
    begin
        fill_rows();
        repeat (16) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        // Nothing issued yet
        check_bit("result.valid", result.valid, 1'b0);
        check_bit("result.rollback_en", result.rollback_en, 1'b0);
        check_perf("perf", perf, '0);

        // A new row every cycle, each checked one cycle later
        for (int i = 0; i < rows.size(); i++)
        begin
            apply_row(rows[i]);
            @(negedge clk);
            row_num = i;
            check_outputs(pending);
        end

        issue.valid = 1'b0;
        squash = '0;
        @(negedge clk);
        row_num = -1;
        check_bit("result.valid", result.valid, 1'b0);
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire
